/* src/rx_serdes_defines.svh */
/*
 * Serial receive front end: build-time constants
 * Word width, fixed input delay and lock-wait length
 */

`ifndef RX_SERDES_DEFINES_SVH
`define RX_SERDES_DEFINES_SVH

// ***********************************************************
// Word framing
// ***********************************************************

// Serial bits per parallel word, valid range 3 to 10
`define RX_WORD_WIDTH 4

// ***********************************************************
// Input path and lock timing
// ***********************************************************

// Clock stages in the fixed input delay line, at least 1
`define RX_DELAY_TAPS 2

// Clocks after reset release before ready rises
// 255 matches an 8-bit settling counter
`define RX_LOCK_WAIT 255

`endif

/* src/rx_serdes_pkg.sv */
/*
 * Serial receive front end: shared types
 * Received-word bundle and output-stage FSM states
 */

`default_nettype none

`include "rx_serdes_defines.svh"

package rx_serdes_pkg;

    // ***********************************************************
    // Word bundle from deserializer to output stage
    // ***********************************************************

    // valid is a single-cycle strobe; data is only meaningful
    // in the cycle where valid is high
    typedef struct packed {
        logic                      valid; // One-cycle word strobe
        logic [`RX_WORD_WIDTH-1:0] data;  // First serial bit in MSB
    } rx_word_t;

    // ***********************************************************
    // Output stage FSM
    // ***********************************************************

    // Lock wait runs once after reset, no way back without reset
    typedef enum logic {
        LOCK_WAIT = 1'b0, // Settling timer running, outputs held
        LOCKED    = 1'b1  // Words pass through to data_o
    } out_state_e;

endpackage : rx_serdes_pkg

`default_nettype wire

/* src/rx_deserializer.sv */
/*
 * Serial-to-parallel deserializer
 * Samples and gates the serial bit, delays it by a fixed tap count,
 * then frames groups of RX_WORD_WIDTH bits into words with a strobe
 */

`timescale 1ns/1ps
`default_nettype none

`include "rx_serdes_defines.svh"

module rx_deserializer (
    input  wire logic               fabric_clk_div, // Divided fabric clock
    input  wire logic               reset_buf_n,    // Async reset, active low
    input  wire logic               enable_n,       // Receive enable, active low
    input  wire logic               data_i,         // Serial bit, one per clock
    output rx_serdes_pkg::rx_word_t word            // Parallel word and strobe
);

    localparam int WORD_W = `RX_WORD_WIDTH;  // Bits per word
    localparam int TAPS   = `RX_DELAY_TAPS;  // Delay line depth
    localparam int CNT_W  = $clog2(WORD_W);  // Bit counter width
    localparam int FILL_W = $clog2(TAPS + 2); // Holds 0..TAPS+1

    logic              sample_q;   // Registered, gated input bit
    logic [TAPS-1:0]   dly_q;      // Fixed delay line, [0] is newest
    logic              dly_bit;    // Bit leaving the delay line
    logic [FILL_W-1:0] fill_cnt_q; // Clocks since reset release
    logic              fill_done;  // Delay line output is a real sample
    logic [CNT_W-1:0]  bit_cnt_q;  // Position within current word
    logic              last_bit;   // Current bit closes the group
    logic [WORD_W-1:0] shift_q;    // Word assembly register
    logic              valid_q;    // Word strobe

    // ***********************************************************
    // Input sampling and enable gating
    // ***********************************************************

    // Received bit reads as zero while the receiver is disabled
    always_ff @(posedge fabric_clk_div) begin
        sample_q <= data_i & ~enable_n; // Gate on sample
    end

    // ***********************************************************
    // Fixed delay line
    // ***********************************************************

    always_ff @(posedge fabric_clk_div) begin
        dly_q[0] <= sample_q;           // Tap 0 fed from sampler
        for (int i = 1; i < TAPS; i++) begin
            dly_q[i] <= dly_q[i-1];     // Ripple one stage per clock
        end
    end

    assign dly_bit = dly_q[TAPS-1]; // Oldest tap

    // Sampler plus TAPS stages must fill before framing starts;
    // the count reaches TAPS+1 just as the first sample sits at the
    // end of the line, then holds there until the next reset
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            fill_cnt_q <= '0;
        end else if (!fill_done) begin
            fill_cnt_q <= fill_cnt_q + 1'b1; // Saturates at TAPS+1
        end
    end

    assign fill_done = (fill_cnt_q == FILL_W'(TAPS + 1));

    // ***********************************************************
    // Word framing
    // ***********************************************************

    assign last_bit = (bit_cnt_q == CNT_W'(WORD_W - 1)); // Final slot

    // Modulo-WORD_W position counter, idle at zero until filled
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q <= '0;
        end else if (fill_done) begin
            if (last_bit) begin
                bit_cnt_q <= '0;               // Wrap, next word begins
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1; // Next slot
            end
        end
    end

    // Strobe rises together with the last bit entering shift_q
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fill_done & last_bit; // One cycle per word
        end
    end

    // Shift left so the first bit of a group ends up in the MSB
    always_ff @(posedge fabric_clk_div) begin
        if (fill_done) begin
            shift_q <= {shift_q[WORD_W-2:0], dly_bit}; // New bit in LSB
        end
    end

    // ***********************************************************
    // Word output
    // ***********************************************************

    assign word = '{valid: valid_q, data: shift_q}; // Straight from flops

endmodule : rx_deserializer

`default_nettype wire

/* src/rx_output_stage.sv */
/*
 * Receiver output stage
 * Lock-wait timer and ready flag, plus the capture register for data_o;
 * words that arrive before the wait completes are dropped
 */

`timescale 1ns/1ps
`default_nettype none

`include "rx_serdes_defines.svh"

module rx_output_stage (
    input  wire logic                    fabric_clk_div, // Divided fabric clock
    input  wire logic                    reset_buf_n,    // Async reset, active low
    input  wire rx_serdes_pkg::rx_word_t word,           // Word from deserializer
    output logic [`RX_WORD_WIDTH-1:0]    data_o,         // Last captured word
    output logic                         ready           // Lock wait done
);

    localparam int WAIT_W = $clog2(`RX_LOCK_WAIT + 1); // Fits full count

    rx_serdes_pkg::out_state_e state_q;    // FSM state
    rx_serdes_pkg::out_state_e state_d;    // FSM next state
    logic [WAIT_W-1:0]         wait_cnt_q; // Clocks since reset release
    logic                      lock_done;  // Wait count reached

    // ***********************************************************
    // Lock-wait FSM
    // ***********************************************************

    assign lock_done = (wait_cnt_q == WAIT_W'(`RX_LOCK_WAIT));

    always_comb begin
        state_d = state_q;                       // Hold by default
        case (state_q)
            rx_serdes_pkg::LOCK_WAIT: begin
                if (lock_done) begin
                    state_d = rx_serdes_pkg::LOCKED; // Settled
                end
            end
            rx_serdes_pkg::LOCKED: begin
                state_d = rx_serdes_pkg::LOCKED;     // Sticky until reset
            end
            default: begin
                state_d = rx_serdes_pkg::LOCK_WAIT;  // Recover to a known state
            end
        endcase
    end

    // Counter runs only during the wait, so it stops at RX_LOCK_WAIT.
    // ready goes high on the edge that sees the full count, which is
    // edge RX_LOCK_WAIT when edges are numbered from 0 after release
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state_q    <= rx_serdes_pkg::LOCK_WAIT;
            wait_cnt_q <= '0;
            ready      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == rx_serdes_pkg::LOCK_WAIT && !lock_done) begin
                wait_cnt_q <= wait_cnt_q + 1'b1; // Count settling clocks
            end
            ready <= (state_d == rx_serdes_pkg::LOCKED); // Registered level
        end
    end

    // ***********************************************************
    // Capture register
    // ***********************************************************

    // Loads only on a strobe once locked, holds between words
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o <= '0;
        end else if (word.valid && state_q == rx_serdes_pkg::LOCKED) begin
            data_o <= word.data; // Take the finished word
        end
    end

endmodule : rx_output_stage

`default_nettype wire

/* src/rx_serdes_top.sv */
/*
 * Serial receive front end, top level
 * Deserializer feeding the lock-wait output stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "rx_serdes_defines.svh"

module rx_serdes_top (
    input  wire logic                 fabric_clk_div, // Divided fabric clock
    input  wire logic                 reset_buf_n,    // Async reset, active low
    input  wire logic                 enable_n,       // Receive enable, active low
    input  wire logic                 data_i,         // Serial bit in
    output logic [`RX_WORD_WIDTH-1:0] data_o,         // Parallel word out
    output logic                      ready           // Receiver settled
);

    // ***********************************************************
    // Internal word path
    // ***********************************************************

    // Strobe plus data, registered at the deserializer output
    rx_serdes_pkg::rx_word_t word;

    // ***********************************************************
    // Deserializer
    // ***********************************************************

    // Bit sampled at edge k closes its group at edge k+TAPS+1
    rx_deserializer rx_deserializer_i (
        .fabric_clk_div (fabric_clk_div), // Shared fabric clock
        .reset_buf_n    (reset_buf_n),    // Shared async reset
        .enable_n       (enable_n),       // Gates the sampled bit
        .data_i         (data_i),         // From the serial pin
        .word           (word)            // To the output stage
    );

    // ***********************************************************
    // Output stage
    // ***********************************************************

    // One more clock to land the word on data_o
    rx_output_stage rx_output_stage_i (
        .fabric_clk_div (fabric_clk_div), // Shared fabric clock
        .reset_buf_n    (reset_buf_n),    // Shared async reset
        .word           (word),           // From the deserializer
        .data_o         (data_o),         // Straight to the pins
        .ready          (ready)           // Straight to the pins
    );

endmodule : rx_serdes_top

`default_nettype wire

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * 4 ns clock, reset held low for the first 3 cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic fabric_clk_div, // Free-running divided clock
    output logic reset_buf_n     // Active-low reset
);

    localparam int HALF_PERIOD_NS = 2; // 4 ns period
    localparam int RESET_CYCLES   = 3; // Rising edges under reset

    initial begin
        fabric_clk_div = 1'b0;
        forever #HALF_PERIOD_NS fabric_clk_div = ~fabric_clk_div;
    end

    initial begin
        reset_buf_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge fabric_clk_div);
        @(negedge fabric_clk_div);
        reset_buf_n = 1'b1; // Release midway between rising edges
    end

endmodule : tb_clock_gen

`default_nettype wire

/* bench/rx_serdes_tb.sv */
/*
 * Testbench for the serial receive front end
 * Sends serial words MSB first, predicts data_o and ready from the
 * latency and lock-wait rules, and checks both on every rising edge
 */

`timescale 1ns/1ps
`default_nettype none

`include "rx_serdes_defines.svh"

module rx_serdes_tb;

    localparam int W              = `RX_WORD_WIDTH; // Bits per word
    localparam int TAPS           = `RX_DELAY_TAPS; // Input delay stages
    localparam int LOCK_WAIT      = `RX_LOCK_WAIT;  // Edge where ready rises
    localparam int TIMEOUT_CYCLES = 2000; // Lock wait plus ~300 words, margin

    logic         fabric_clk_div; // From clock source
    logic         reset_buf_n;    // From clock source
    logic         enable_n;       // Receive enable, active low
    logic         data_i;         // Serial bit to DUT
    logic [W-1:0] data_o;         // Parallel word from DUT
    logic         ready;          // Lock flag from DUT

    integer       seed;              // Random stream state
    int           cycle_cnt;         // Watchdog count
    int           edge_cnt = 0;      // Rising edges since release
    int           words_sent = 0;    // Groups driven by stimulus
    int           words_done = 0;    // Groups past their due edge
    int           grp_len = 0;       // Bits gathered in current group
    logic [W-1:0] grp_bits = '0;     // Current group, first bit ends in MSB
    logic [W-1:0] exp_data = '0;     // Predicted data_o
    logic         exp_ready = 1'b0;  // Predicted ready
    int           due_q[$];          // Edge where each word lands
    logic [W-1:0] word_q[$];         // Words waiting for their edge
    rx_serdes_pkg::out_state_e phase = rx_serdes_pkg::LOCK_WAIT; // For log

    // ***********************************************************
    // Clock, reset and DUT
    // ***********************************************************

    tb_clock_gen tb_clock_gen_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n)
    );

    rx_serdes_top rx_serdes_top_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .data_o         (data_o),
        .ready          (ready)
    );

    // ***********************************************************
    // Failure and stimulus helpers
    // ***********************************************************

    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // One bit per falling edge, MSB first
    task automatic send_word(input logic [W-1:0] w, input logic en_n);
        for (int i = W - 1; i >= 0; i--) begin
            data_i   = w[i];
            enable_n = en_n;             // Held for the whole group
            @(negedge fabric_clk_div);
        end
        words_sent = words_sent + 1;
    endtask

    task automatic send_random_words(input int n, input logic en_n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            send_word(rnd[W-1:0], en_n);
        end
    endtask

    // ***********************************************************
    // Reference model
    // ***********************************************************

    // Group ending with the bit sampled at edge k lands after edge k+TAPS+2
    always @(posedge fabric_clk_div) begin : ref_model
        int k;
        if (reset_buf_n) begin
            k        = edge_cnt;          // Index of this edge
            edge_cnt = edge_cnt + 1;
            if (k == LOCK_WAIT) begin
                phase = rx_serdes_pkg::LOCKED;
                $display("Lock wait over at %0t, output stage %s", $time, phase.name());
            end
            if (k >= LOCK_WAIT) begin
                exp_ready <= 1'b1;        // Rises at edge LOCK_WAIT, sticky
            end
            grp_bits = {grp_bits[W-2:0], data_i & ~enable_n}; // Gated bit
            grp_len  = grp_len + 1;
            if (grp_len == W) begin
                due_q.push_back(k + TAPS + 2);
                word_q.push_back(grp_bits);
                grp_len = 0;
            end
            if (due_q.size() != 0 && due_q[0] == k) begin
                if (k > LOCK_WAIT) begin  // Ready already high before this edge
                    exp_data <= word_q[0];
                end
                void'(due_q.pop_front());
                void'(word_q.pop_front());
                words_done = words_done + 1;
            end
        end
    end

    // ***********************************************************
    // Assertions
    // ***********************************************************

    data_o_check: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        data_o == exp_data)
    else begin
        $display("** Error at %0t: data_o expected %h, actual %h",
                 $time, $sampled(exp_data), $sampled(data_o));
        report_failure();
    end

    ready_check: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        ready == exp_ready)
    else begin
        $display("** Error at %0t: ready expected %b, actual %b",
                 $time, $sampled(exp_ready), $sampled(ready));
        report_failure();
    end

    // Once up, ready stays up until the next reset
    ready_hold_check: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        !$fell(ready))
    else begin
        $display("** Error at %0t: ready expected 1, actual 0", $time);
        report_failure();
    end

    // ***********************************************************
    // Watchdog
    // ***********************************************************

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge fabric_clk_div);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_failure();
    end

    // ***********************************************************
    // Stimulus
    // ***********************************************************

    initial begin : stimulus
        logic [31:0] rnd;
        seed     = 32'h7894e760;
        data_i   = 1'b0;
        enable_n = 1'b0;
        wait (reset_buf_n === 1'b1);       // First bit lands at edge 0

        send_random_words(70, 1'b0);       // Spans the lock wait and its end
        send_random_words(60, 1'b0);       // Locked traffic
        send_random_words(6, 1'b1);        // Receiver disabled, zero words
        send_random_words(20, 1'b0);       // Enabled again
        rnd = $random(seed);
        for (int i = 0; i < 8; i++) begin
            send_word(rnd[W-1:0], 1'b0);   // Same word back to back
        end
        for (int i = 0; i < 6; i++) begin
            send_word({W{1'b1}}, 1'b0);    // All ones
        end
        for (int i = 0; i < 6; i++) begin
            send_word({W{1'b0}}, 1'b0);    // All zeros
        end
        send_word({1'b1, {(W-1){1'b0}}}, 1'b0); // Lone MSB
        send_word({{(W-1){1'b0}}, 1'b1}, 1'b0); // Lone LSB
        send_random_words(20, 1'b0);

        // Let every sent group reach its due edge, then one more check
        while (words_done < words_sent) begin
            @(negedge fabric_clk_div);
        end
        @(posedge fabric_clk_div);
        @(negedge fabric_clk_div);

        $display("TEST OK");
        $finish;
    end

endmodule : rx_serdes_tb

`default_nettype wire

/* rx_serdes.f */
+incdir+src
src/rx_serdes_pkg.sv
src/rx_deserializer.sv
src/rx_output_stage.sv
src/rx_serdes_top.sv
bench/tb_clock_gen.sv
bench/rx_serdes_tb.sv
